// File: Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rename_pkg.sv
      - verilog/map_table.sv
      - verilog/free_list.sv
      - verilog/arch_map_table.sv
      - verilog/rename_ctrl.sv
      - verilog/rename_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_rename.sv

// File: compile.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/arch_map_table.sv
verilog/rename_ctrl.sv
verilog/rename_top.sv
testbench/tb_rename.sv

// File: testbench/tb_rename.sv
// Rename stage testbench with step table, reference model and output checks
`timescale 1ns/1ps
`include "rename_params.svh"

module tb_rename import rename_pkg::*; ();

    localparam int RAND_STEPS = 80;
    localparam int MAX_CYCLES = 1000;

    // Inputs for a single cycle
    typedef struct packed {
        dp_req_t [`DP_NUM-1:0]  req;
        cdb_t    [`CDB_NUM-1:0] cdb;
        logic    [1:0]          rt_cnt;
        logic                   rollback;
    } step_t;

    logic                       clk_i;
    logic                       rst_i;
    logic                       rollback_i;
    cdb_t    [`CDB_NUM-1:0]     cdb_i;
    dp_req_t [`DP_NUM-1:0]      dp_req_i;
    rt_t     [`DP_NUM-1:0]      rt_i;
    logic    [`DP_NUM-1:0]      dp_grant_o;
    tag_t    [`DP_NUM-1:0]      dp_tag_new_o;
    mt_dp_t  [`DP_NUM-1:0]      mt_dp_o;

    // ========================================
    // Reference model state
    // ========================================
    tag_t   mt_tag [`ARCH_REG_NUM];
    bit     mt_rdy [`ARCH_REG_NUM];
    tag_t   amt    [`ARCH_REG_NUM];
    tag_t   fl     [`PHYS_REG_NUM];
    int     head_spec;
    int     head_rt;
    int     tail;
    // Renamed but not yet retired in age order
    rt_t    rob [$];
    step_t  steps [$];
    rt_t    [`DP_NUM-1:0] cur_rt;
    // Expected outputs of the current step
    bit     exp_grant [`DP_NUM];
    bit     exp_wr    [`DP_NUM];
    tag_t   exp_new   [`DP_NUM];
    mt_dp_t exp_dp    [`DP_NUM];
    int     exp_need;

    rename_top uut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rollback_i   (rollback_i),
        .cdb_i        (cdb_i),
        .dp_req_i     (dp_req_i),
        .rt_i         (rt_i),
        .dp_grant_o   (dp_grant_o),
        .dp_tag_new_o (dp_tag_new_o),
        .mt_dp_o      (mt_dp_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    function automatic dp_req_t make_req(input bit v, input int rs1, input int rs2, input int rd);
        dp_req_t r;
        r.valid = v;
        r.rs1   = arch_reg_t'(rs1);
        r.rs2   = arch_reg_t'(rs2);
        r.rd    = arch_reg_t'(rd);
        return r;
    endfunction

    function automatic cdb_t make_cdb(input bit v, input int tag);
        cdb_t c;
        c.valid = v;
        c.tag   = tag_t'(tag);
        return c;
    endfunction

    task automatic add_step(input dp_req_t r0, input dp_req_t r1, input cdb_t c0,
                            input int rt_cnt, input bit rb);
        step_t s;
        s.req[0]   = r0;
        s.req[1]   = r1;
        s.cdb[0]   = c0;
        s.cdb[1]   = '0;
        s.rt_cnt   = 2'(rt_cnt);
        s.rollback = rb;
        steps.push_back(s);
    endtask

    function automatic bit on_cdb(input cdb_t [`CDB_NUM-1:0] cdb, input tag_t t);
        bit hit;
        hit = 1'b0;
        for (int c = 0; c < `CDB_NUM; c++) begin
            if (cdb[c].valid && cdb[c].tag == t) hit = 1'b1;
        end
        return hit;
    endfunction

    // ========================================
    // Stimulus table
    // ========================================
    task automatic build_table();
        step_t s;
        cdb_t  idle;
        idle = '0;
        // Reset map and r0 writes that need no tag
        add_step(make_req(1, 5, 31, 0), make_req(1, 0, 7, 0), idle, 0, 0);
        // First tags in order and in-group bypass
        add_step(make_req(1, 1, 2, 3), make_req(0, 0, 0, 0), idle, 0, 0);
        add_step(make_req(1, 3, 3, 4), make_req(1, 4, 0, 5), idle, 0, 0);
        // WAW inside a group
        add_step(make_req(1, 1, 1, 6), make_req(1, 6, 2, 6), idle, 0, 0);
        add_step(make_req(1, 2, 2, 0), make_req(1, 6, 0, 7), idle, 0, 0);
        // Wakeup seen the same cycle and kept
        add_step(make_req(1, 3, 4, 0), make_req(0, 0, 0, 0), make_cdb(1, 32), 0, 0);
        add_step(make_req(1, 3, 0, 0), make_req(0, 0, 0, 0), idle, 0, 0);
        // Drain the free list
        for (int k = 0; k < 13; k++) begin
            add_step(make_req(1, k, k + 1, 8 + k), make_req(1, k + 2, 3, 9 + k), idle, 0, 0);
        end
        // Held request stalled until a retire frees a tag
        add_step(make_req(1, 1, 2, 9), make_req(1, 3, 4, 10), idle, 0, 0);
        add_step(make_req(1, 1, 2, 9), make_req(1, 3, 4, 10), idle, 1, 0);
        add_step(make_req(1, 1, 2, 9), make_req(1, 3, 4, 10), idle, 0, 0);
        // Retire two more and roll back
        add_step(make_req(0, 0, 0, 0), make_req(0, 0, 0, 0), idle, 2, 0);
        add_step(make_req(1, 1, 2, 3), make_req(0, 0, 0, 0), idle, 0, 1);
        add_step(make_req(1, 3, 4, 6), make_req(1, 5, 6, 7), idle, 0, 0);
        // Random tail without retire in a rollback cycle
        for (int n = 0; n < RAND_STEPS; n++) begin
            s.rollback = ($urandom % 16) == 0;
            s.rt_cnt   = s.rollback ? 2'd0 : 2'($urandom % 3);
            for (int i = 0; i < `DP_NUM; i++) begin
                s.req[i] = make_req($urandom % 4 != 0, $urandom % 32, $urandom % 32,
                                    $urandom % 32);
            end
            for (int c = 0; c < `CDB_NUM; c++) begin
                s.cdb[c] = make_cdb($urandom % 2, $urandom % 64);
            end
            steps.push_back(s);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    task automatic reset_model();
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            mt_tag[r] = tag_t'(r);
            mt_rdy[r] = 1'b1;
            amt[r]    = tag_t'(r);
        end
        for (int k = 0; k < `PHYS_REG_NUM; k++) begin
            fl[k] = tag_t'(k + `ARCH_REG_NUM);
        end
        head_spec = 0;
        head_rt   = 0;
        tail      = `PHYS_REG_NUM - `ARCH_REG_NUM;
        rob.delete();
    endtask

    task automatic predict(input step_t s);
        int free_cnt;
        bit ok;
        bit alloc;
        dp_req_t q;
        free_cnt = tail - head_spec;
        exp_need = 0;
        ok       = !s.rollback;
        for (int i = 0; i < `DP_NUM; i++) begin
            q            = s.req[i];
            alloc        = q.valid && (q.rd != `ZERO_REG);
            exp_grant[i] = ok && q.valid && (exp_need + alloc <= free_cnt);
            exp_new[i]   = '0;
            if (!exp_grant[i]) begin
                ok = 1'b0;
            end else if (alloc) begin
                exp_new[i] = fl[(head_spec + exp_need) % `PHYS_REG_NUM];
                exp_need++;
            end
            exp_wr[i]            = exp_grant[i] && alloc;
            exp_dp[i].tag1       = mt_tag[q.rs1];
            exp_dp[i].tag1_ready = mt_rdy[q.rs1] || on_cdb(s.cdb, mt_tag[q.rs1]);
            exp_dp[i].tag2       = mt_tag[q.rs2];
            exp_dp[i].tag2_ready = mt_rdy[q.rs2] || on_cdb(s.cdb, mt_tag[q.rs2]);
            exp_dp[i].tag_old    = mt_tag[q.rd];
            // Older renames in the group take over
            for (int j = 0; j < i; j++) begin
                if (exp_wr[j] && s.req[j].rd == q.rs1) begin
                    exp_dp[i].tag1       = exp_new[j];
                    exp_dp[i].tag1_ready = 1'b0;
                end
                if (exp_wr[j] && s.req[j].rd == q.rs2) begin
                    exp_dp[i].tag2       = exp_new[j];
                    exp_dp[i].tag2_ready = 1'b0;
                end
                if (exp_wr[j] && s.req[j].rd == q.rd) exp_dp[i].tag_old = exp_new[j];
            end
        end
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < `DP_NUM; i++) begin
            check_value($sformatf("dp_grant_o[%0d]", i), dp_grant_o[i], exp_grant[i]);
            check_value($sformatf("dp_tag_new_o[%0d]", i), dp_tag_new_o[i], exp_new[i]);
            check_value($sformatf("mt_dp_o[%0d].tag1", i), mt_dp_o[i].tag1, exp_dp[i].tag1);
            check_value($sformatf("mt_dp_o[%0d].tag1_ready", i), mt_dp_o[i].tag1_ready,
                        exp_dp[i].tag1_ready);
            check_value($sformatf("mt_dp_o[%0d].tag2", i), mt_dp_o[i].tag2, exp_dp[i].tag2);
            check_value($sformatf("mt_dp_o[%0d].tag2_ready", i), mt_dp_o[i].tag2_ready,
                        exp_dp[i].tag2_ready);
            check_value($sformatf("mt_dp_o[%0d].tag_old", i), mt_dp_o[i].tag_old,
                        exp_dp[i].tag_old);
        end
    endtask

    task automatic update_model(input step_t s);
        tag_t amt_prev [`ARCH_REG_NUM];
        rt_t  e;
        amt_prev = amt;
        // Retire in slot order
        for (int k = 0; k < `DP_NUM; k++) begin
            if (cur_rt[k].valid) begin
                amt[cur_rt[k].rd]          = cur_rt[k].tag;
                fl[tail % `PHYS_REG_NUM]   = cur_rt[k].tag_old;
                tail++;
                head_rt++;
                void'(rob.pop_front());
            end
        end
        if (s.rollback) begin
            for (int r = 0; r < `ARCH_REG_NUM; r++) begin
                mt_tag[r] = amt_prev[r];
                mt_rdy[r] = 1'b1;
            end
            head_spec = head_rt;
            rob.delete();
        end else begin
            for (int r = 0; r < `ARCH_REG_NUM; r++) begin
                if (on_cdb(s.cdb, mt_tag[r])) mt_rdy[r] = 1'b1;
            end
            // Renames after wakeup
            for (int i = 0; i < `DP_NUM; i++) begin
                if (exp_wr[i]) begin
                    mt_tag[s.req[i].rd] = exp_new[i];
                    mt_rdy[s.req[i].rd] = 1'b0;
                    e.valid   = 1'b1;
                    e.rd      = s.req[i].rd;
                    e.tag     = exp_new[i];
                    e.tag_old = exp_dp[i].tag_old;
                    rob.push_back(e);
                end
            end
            head_spec += exp_need;
        end
    endtask

    // Retire slots come from the oldest renamed instructions
    task automatic drive_step(input step_t s);
        rt_t [`DP_NUM-1:0] rt_v;
        rt_v = '0;
        for (int k = 0; k < `DP_NUM; k++) begin
            if (k < s.rt_cnt && k < rob.size()) rt_v[k] = rob[k];
        end
        rollback_i = s.rollback;
        cdb_i      = s.cdb;
        dp_req_i   = s.req;
        rt_i       = rt_v;
        cur_rt     = rt_v;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        rollback_i = 1'b0;
        cdb_i      = '0;
        dp_req_i   = '0;
        rt_i       = '0;
        cur_rt     = '0;
        void'($urandom(32'h317f));
        build_table();
        reset_model();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        foreach (steps[n]) begin
            drive_step(steps[n]);
            #1;
            predict(steps[n]);
            compare_outputs();
            @(posedge clk_i);
            update_model(steps[n]);
            @(negedge clk_i);
        end
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk_i);
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: verilog/arch_map_table.sv
// Committed register-to-tag map, updated by in-order retire
`timescale 1ns/1ps
`include "rename_params.svh"

module arch_map_table import rename_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  rt_t          [`DP_NUM-1:0]          rt_i,
    output tag_t         [`ARCH_REG_NUM-1:0]    amt_o
);

    // ========================================
    // Committed state
    // ========================================
    tag_t amt [`ARCH_REG_NUM];

    always_comb begin
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            amt_o[r] = amt[r];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Same identity map as the speculative table
            for (int r = 0; r < `ARCH_REG_NUM; r++) begin
                amt[r] <= tag_t'(r);
            end
        end else begin
            // Older slot first, younger slot wins on equal rd
            for (int k = 0; k < `DP_NUM; k++) begin
                if (rt_i[k].valid) begin
                    amt[rt_i[k].rd] <= rt_i[k].tag;
                end
            end
        end
    end

endmodule

// File: verilog/free_list.sv
// Circular free-tag queue with speculative head, retire head and tail
`timescale 1ns/1ps
`include "rename_params.svh"

module free_list import rename_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        rollback_i,
    input  logic        [1:0]           alloc_num,
    input  rt_t         [`DP_NUM-1:0]   rt_i,
    output tag_t        [`DP_NUM-1:0]   head_tags_o,
    output cnt_t                        free_cnt_o
);

    tag_t fl_mem [`PHYS_REG_NUM];

    // Pointers carry a wrap bit
    cnt_t head_spec;
    cnt_t head_rt;
    cnt_t tail;
    cnt_t head_rt_next;
    cnt_t rd_ptr [`DP_NUM];
    cnt_t wr_ptr [`DP_NUM];
    logic [1:0] rt_num;

    // Next tags offered to dispatch
    always_comb begin
        for (int k = 0; k < `DP_NUM; k++) begin
            rd_ptr[k]      = head_spec + cnt_t'(k);
            head_tags_o[k] = fl_mem[rd_ptr[k][`TAG_IDX_WIDTH-1:0]];
        end
    end

    // Pack valid retire slots onto the tail
    always_comb begin
        rt_num = '0;
        for (int k = 0; k < `DP_NUM; k++) begin
            wr_ptr[k] = tail + cnt_t'(rt_num);
            if (rt_i[k].valid) begin
                rt_num = rt_num + 2'd1;
            end
        end
    end

    // Retired tags left the queue in allocation order
    assign head_rt_next = head_rt + cnt_t'(rt_num);
    assign free_cnt_o   = tail - head_spec;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Tags above the identity map are free
            for (int k = 0; k < `PHYS_REG_NUM; k++) begin
                fl_mem[k] <= tag_t'(k + `ARCH_REG_NUM);
            end
            head_spec <= '0;
            head_rt   <= '0;
            tail      <= cnt_t'(`PHYS_REG_NUM - `ARCH_REG_NUM);
        end else begin
            for (int k = 0; k < `DP_NUM; k++) begin
                if (rt_i[k].valid) begin
                    fl_mem[wr_ptr[k][`TAG_IDX_WIDTH-1:0]] <= rt_i[k].tag_old;
                end
            end
            tail    <= tail + cnt_t'(rt_num);
            head_rt <= head_rt_next;
            // Rewind drops every speculative allocation
            if (rollback_i) begin
                head_spec <= head_rt_next;
            end else begin
                head_spec <= head_spec + cnt_t'(alloc_num);
            end
        end
    end

endmodule

// File: verilog/map_table.sv
// Speculative map table with ready bits, bypassed dispatch read, CDB wakeup and rollback
`timescale 1ns/1ps
`include "rename_params.svh"

module map_table import rename_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                rollback_i,
    input  cdb_t         [`CDB_NUM-1:0]         cdb_i,
    input  dp_mt_read_t  [`DP_NUM-1:0]          dp_mt_read_i,
    input  dp_mt_write_t [`DP_NUM-1:0]          dp_mt_write_i,
    input  tag_t         [`ARCH_REG_NUM-1:0]    amt_i,
    output mt_dp_t       [`DP_NUM-1:0]          mt_dp_o
);

    // ========================================
    // State
    // ========================================
    mt_entry_t mt_entry [`ARCH_REG_NUM];
    mt_entry_t mt_next  [`ARCH_REG_NUM];

    // Ready bit as seen this cycle, CDB folded in
    function automatic logic entry_ready(mt_entry_t entry, cdb_t [`CDB_NUM-1:0] cdb);
        logic rdy;
        rdy = entry.tag_ready;
        for (int c = 0; c < `CDB_NUM; c++) begin
            if (cdb[c].valid && (cdb[c].tag == entry.tag)) begin
                rdy = 1'b1;
            end
        end
        return rdy;
    endfunction

    // ========================================
    // Dispatch read path
    // ========================================
    always_comb begin
        for (int i = 0; i < `DP_NUM; i++) begin
            // Table lookup with same-cycle wakeup
            mt_dp_o[i].tag1       = mt_entry[dp_mt_read_i[i].rs1].tag;
            mt_dp_o[i].tag1_ready = entry_ready(mt_entry[dp_mt_read_i[i].rs1], cdb_i);
            mt_dp_o[i].tag2       = mt_entry[dp_mt_read_i[i].rs2].tag;
            mt_dp_o[i].tag2_ready = entry_ready(mt_entry[dp_mt_read_i[i].rs2], cdb_i);
            mt_dp_o[i].tag_old    = mt_entry[dp_mt_write_i[i].rd].tag;
            // Earlier slots in the group override, youngest last
            for (int j = 0; j < i; j++) begin
                if (dp_mt_write_i[j].wr_en) begin
                    if (dp_mt_write_i[j].rd == dp_mt_read_i[i].rs1) begin
                        mt_dp_o[i].tag1       = dp_mt_write_i[j].tag;
                        mt_dp_o[i].tag1_ready = 1'b0;
                    end
                    if (dp_mt_write_i[j].rd == dp_mt_read_i[i].rs2) begin
                        mt_dp_o[i].tag2       = dp_mt_write_i[j].tag;
                        mt_dp_o[i].tag2_ready = 1'b0;
                    end
                    // WAW inside the group
                    if (dp_mt_write_i[j].rd == dp_mt_write_i[i].rd) begin
                        mt_dp_o[i].tag_old    = dp_mt_write_i[j].tag;
                    end
                end
            end
        end
    end

    // ========================================
    // Next state for normal operation
    // ========================================
    always_comb begin
        mt_next = mt_entry;
        // Wakeup on matching broadcast
        for (int e = 0; e < `ARCH_REG_NUM; e++) begin
            for (int c = 0; c < `CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag == mt_entry[e].tag)) begin
                    mt_next[e].tag_ready = 1'b1;
                end
            end
        end
        // Renames last, so a write beats a wakeup
        for (int i = 0; i < `DP_NUM; i++) begin
            if (dp_mt_write_i[i].wr_en) begin
                mt_next[dp_mt_write_i[i].rd].tag       = dp_mt_write_i[i].tag;
                mt_next[dp_mt_write_i[i].rd].tag_ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity map, all ready
            for (int e = 0; e < `ARCH_REG_NUM; e++) begin
                mt_entry[e].tag       <= tag_t'(e);
                mt_entry[e].tag_ready <= 1'b1;
            end
        end else if (rollback_i) begin
            // Restore committed map
            for (int e = 0; e < `ARCH_REG_NUM; e++) begin
                mt_entry[e].tag       <= amt_i[e];
                mt_entry[e].tag_ready <= 1'b1;
            end
        end else begin
            mt_entry <= mt_next;
        end
    end

endmodule

// File: verilog/rename_ctrl.sv
// Dispatch group control: in-order grant against free count and tag assignment
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_ctrl import rename_pkg::*; (
    input  logic                            rollback_i,
    input  dp_req_t      [`DP_NUM-1:0]      dp_req_i,
    input  cnt_t                            free_cnt_i,
    input  tag_t         [`DP_NUM-1:0]      head_tags_i,
    output logic         [`DP_NUM-1:0]      dp_grant_o,
    output tag_t         [`DP_NUM-1:0]      dp_tag_new_o,
    output dp_mt_read_t  [`DP_NUM-1:0]      dp_mt_read_o,
    output dp_mt_write_t [`DP_NUM-1:0]      dp_mt_write_o,
    output logic         [1:0]              alloc_num_o
);

    logic [`DP_NUM-1:0] slot_alloc;
    logic [1:0]         need_cnt;
    logic               prev_ok;

    // Writes to r0 are never renamed
    always_comb begin
        for (int i = 0; i < `DP_NUM; i++) begin
            slot_alloc[i] = dp_req_i[i].valid &&
                            (dp_req_i[i].rd != arch_reg_t'(`ZERO_REG));
        end
    end

    // ========================================
    // Grant and tag assignment
    // ========================================
    always_comb begin
        need_cnt = '0;
        // Nothing goes out while rolling back
        prev_ok  = ~rollback_i;
        for (int i = 0; i < `DP_NUM; i++) begin
            dp_grant_o[i]   = prev_ok && dp_req_i[i].valid &&
                              ((cnt_t'(need_cnt) + cnt_t'(slot_alloc[i])) <= free_cnt_i);
            dp_tag_new_o[i] = '0;
            if (dp_grant_o[i]) begin
                if (slot_alloc[i]) begin
                    dp_tag_new_o[i] = head_tags_i[need_cnt];
                    need_cnt        = need_cnt + 2'd1;
                end
            end else begin
                // Stall this slot and every younger one
                prev_ok = 1'b0;
            end
            dp_mt_read_o[i].rs1    = dp_req_i[i].rs1;
            dp_mt_read_o[i].rs2    = dp_req_i[i].rs2;
            // rd always goes out, tag_old lookup needs it
            dp_mt_write_o[i].wr_en = dp_grant_o[i] && slot_alloc[i];
            dp_mt_write_o[i].rd    = dp_req_i[i].rd;
            dp_mt_write_o[i].tag   = dp_tag_new_o[i];
        end
        alloc_num_o = need_cnt;
    end

endmodule

// File: verilog/rename_params.svh
// Width and count macros for the rename stage
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Dispatch and retire width
`define DP_NUM          2
// CDB broadcasts per cycle
`define CDB_NUM         2

// Register file sizes
`define ARCH_REG_NUM    32
`define PHYS_REG_NUM    64

// Index widths
`define ARCH_IDX_WIDTH  5
`define TAG_IDX_WIDTH   6

// Hardwired zero register
`define ZERO_REG        0

`endif

// File: verilog/rename_pkg.sv
// Rename stage types: register index, tag, counter and interface structs
`include "rename_params.svh"

package rename_pkg;

    // Basic widths
    typedef logic [`ARCH_IDX_WIDTH-1:0] arch_reg_t;
    typedef logic [`TAG_IDX_WIDTH-1:0]  tag_t;
    // One extra bit, occupancy reaches PHYS_REG_NUM
    typedef logic [`TAG_IDX_WIDTH:0]    cnt_t;

    // Completion broadcast
    typedef struct packed {
        logic       valid;
        tag_t       tag;
    } cdb_t;

    // Dispatch slot request from decode
    typedef struct packed {
        logic       valid;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        arch_reg_t  rd;
    } dp_req_t;

    // Source lookup
    typedef struct packed {
        arch_reg_t  rs1;
        arch_reg_t  rs2;
    } dp_mt_read_t;

    // Destination rename
    typedef struct packed {
        logic       wr_en;
        arch_reg_t  rd;
        tag_t       tag;
    } dp_mt_write_t;

    // Lookup result back to dispatch
    typedef struct packed {
        tag_t       tag1;
        logic       tag1_ready;
        tag_t       tag2;
        logic       tag2_ready;
        tag_t       tag_old;
    } mt_dp_t;

    typedef struct packed {
        tag_t       tag;
        logic       tag_ready;
    } mt_entry_t;

    // Retire slot, only instructions with a destination
    typedef struct packed {
        logic       valid;
        arch_reg_t  rd;
        tag_t       tag;
        tag_t       tag_old;
    } rt_t;

endpackage

// File: verilog/rename_top.sv
// Rename stage top: control, map table, free list and architectural map
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_top import rename_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        rollback_i,
    input  cdb_t    [`CDB_NUM-1:0]      cdb_i,
    input  dp_req_t [`DP_NUM-1:0]       dp_req_i,
    input  rt_t     [`DP_NUM-1:0]       rt_i,
    output logic    [`DP_NUM-1:0]       dp_grant_o,
    output tag_t    [`DP_NUM-1:0]       dp_tag_new_o,
    output mt_dp_t  [`DP_NUM-1:0]       mt_dp_o
);

    // Control to tables
    dp_mt_read_t  [`DP_NUM-1:0]         dp_mt_read;
    dp_mt_write_t [`DP_NUM-1:0]         dp_mt_write;
    logic         [1:0]                 alloc_num;
    // Free list back to control
    cnt_t                               free_cnt;
    tag_t         [`DP_NUM-1:0]         head_tags;
    // Committed map for rollback
    tag_t         [`ARCH_REG_NUM-1:0]   amt_tags;

    rename_ctrl u_ctrl (
        .rollback_i    (rollback_i),
        .dp_req_i      (dp_req_i),
        .free_cnt_i    (free_cnt),
        .head_tags_i   (head_tags),
        .dp_grant_o    (dp_grant_o),
        .dp_tag_new_o  (dp_tag_new_o),
        .dp_mt_read_o  (dp_mt_read),
        .dp_mt_write_o (dp_mt_write),
        .alloc_num_o   (alloc_num)
    );

    map_table u_mt (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rollback_i    (rollback_i),
        .cdb_i         (cdb_i),
        .dp_mt_read_i  (dp_mt_read),
        .dp_mt_write_i (dp_mt_write),
        .amt_i         (amt_tags),
        .mt_dp_o       (mt_dp_o)
    );

    free_list u_fl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rollback_i    (rollback_i),
        .alloc_num     (alloc_num),
        .rt_i          (rt_i),
        .head_tags_o   (head_tags),
        .free_cnt_o    (free_cnt)
    );

    arch_map_table u_amt (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rt_i          (rt_i),
        .amt_o         (amt_tags)
    );

endmodule
